// File: logic/fetch_pkg.sv
// Widths and encodings shared by the fetch subsystem
// Word and instruction size are fixed at 32 bits

package fetch_pkg;

  //////////////////////////////
  // Datapath widths
  //////////////////////////////
  localparam int XLEN        = 32;        // Address, instruction and data width
  localparam int STRB_WIDTH  = XLEN / 8;  // One strobe per byte
  localparam int INSTR_BYTES = 4;         // PC step, no compressed instructions

  //////////////////////////////
  // Arbiter owner
  //////////////////////////////
  // Requester whose read is in flight in the memory
  typedef enum logic {
    OWNER_DATA  = 1'b0,
    OWNER_FETCH = 1'b1
  } arb_owner_e;

endpackage

// File: logic/fetch_unit.sv
// Instruction fetch unit, expects a memory that answers every read one cycle later
// Responses cannot stall, so at most two words are held or in flight
// Misaligned jump traps and stops fetching until the next aligned jump

module fetch_unit import fetch_pkg::*; #(
  parameter logic [XLEN-1:0] BOOT_ADDR = 32'h8000_0000
) (
  input  logic            clk_i,
  input  logic            rstn_i,
  // Memory request
  output logic            fetch_req_valid_o,
  input  logic            fetch_req_ready_i,
  output logic [XLEN-1:0] fetch_req_addr_o,
  // Memory response
  input  logic            fetch_rsp_valid_i,
  input  logic [XLEN-1:0] fetch_rsp_data_i,
  // Decoder side
  output logic [XLEN-1:0] dec_instr_o,
  output logic [XLEN-1:0] dec_pc_o,
  output logic            dec_valid_o,
  input  logic            dec_ready_i,
  // Redirect
  input  logic            jmp_valid_i,
  input  logic [XLEN-1:0] jmp_addr_i,
  // Trap
  output logic            exception_o,
  output logic [XLEN-1:0] fault_addr_o
);

  localparam int CNT_W   = 2;
  localparam int ALIGN_W = $clog2(INSTR_BYTES);

  typedef enum logic [1:0] {
    S_EMPTY,  // Nothing held
    S_BUSY,   // Output register holds a word
    S_FULL,   // Output and skid registers hold words
    S_ADDR    // Waiting to issue from a new address
  } ifu_state_e;

  ifu_state_e      state_q, state_next;
  logic [XLEN-1:0] out_q, skid_q;
  logic [CNT_W-1:0] pend_q, pend_next;  // All reads in flight
  logic [CNT_W-1:0] drop_q;             // Oldest in-flight reads to throw away
  logic [CNT_W-1:0] useful, held;
  logic [CNT_W:0]   occ;
  logic            trap_q, jmp_ok;
  logic            fetch_req_fire, dec_fire, rsp_keep, rsp_drop;
  logic            load, flow, fill, unload, drain, restart;

  assign fetch_req_fire = fetch_req_valid_o && fetch_req_ready_i;
  assign dec_fire       = dec_valid_o && dec_ready_i;
  assign rsp_keep       = fetch_rsp_valid_i && (drop_q == '0);
  assign rsp_drop       = fetch_rsp_valid_i && (drop_q != '0);
  assign jmp_ok         = jmp_valid_i && (jmp_addr_i[ALIGN_W-1:0] == '0);

  //////////////////////////////
  // Occupancy and request gate
  //////////////////////////////
  always_comb begin
    case (state_q)
      S_BUSY:  held = CNT_W'(1);
      S_FULL:  held = CNT_W'(2);
      default: held = '0;
    endcase
  end

  assign useful    = pend_q - drop_q;
  assign pend_next = pend_q + CNT_W'(fetch_req_fire) - CNT_W'(fetch_rsp_valid_i);
  // Words that remain once this cycle's decoder transfer leaves
  assign occ = {1'b0, held} + {1'b0, useful} - (CNT_W + 1)'(dec_fire);

  assign fetch_req_valid_o = !trap_q && (occ < (CNT_W + 1)'(2));  // Room for one more

  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      pend_q <= '0;
      drop_q <= '0;
    end else begin
      pend_q <= pend_next;
      if (jmp_valid_i) begin
        drop_q <= pend_next;  // Everything outstanding is stale
      end else if (rsp_drop) begin
        drop_q <= drop_q - CNT_W'(1);
      end
    end
  end

  //////////////////////////////
  // Request address and PC
  //////////////////////////////
  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      fetch_req_addr_o <= BOOT_ADDR;
      dec_pc_o         <= BOOT_ADDR;
    end else begin
      if (jmp_ok) begin
        fetch_req_addr_o <= jmp_addr_i;
      end else if (fetch_req_fire) begin
        fetch_req_addr_o <= fetch_req_addr_o + XLEN'(INSTR_BYTES);
      end
      if (jmp_ok) begin
        dec_pc_o <= jmp_addr_i;
      end else if (dec_fire) begin
        dec_pc_o <= dec_pc_o + XLEN'(INSTR_BYTES);
      end
    end
  end

  // Trap level, cleared only by an aligned jump
  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      trap_q <= 1'b0;
    end else if (jmp_valid_i) begin
      trap_q <= !jmp_ok;
    end
  end

  always_ff @(posedge clk_i) begin
    if (jmp_valid_i && !jmp_ok) begin
      fault_addr_o <= jmp_addr_i;
    end
  end

  assign exception_o = trap_q;

  //////////////////////////////
  // Skid buffer FSM
  //////////////////////////////
  always_comb begin
    load    = (state_q == S_EMPTY) && rsp_keep;
    flow    = (state_q == S_BUSY) && rsp_keep && dec_fire;
    fill    = (state_q == S_BUSY) && rsp_keep && !dec_fire;
    unload  = (state_q == S_BUSY) && !rsp_keep && dec_fire;
    drain   = (state_q == S_FULL) && dec_fire;  // No response can land while full
    restart = (state_q == S_ADDR) && fetch_req_fire;
  end

  always_comb begin
    state_next = state_q;
    if (load || flow || drain) state_next = S_BUSY;
    if (fill)                  state_next = S_FULL;
    if (unload)                state_next = S_EMPTY;
    if (restart)               state_next = S_EMPTY;
    if (jmp_valid_i)           state_next = S_ADDR;  // Held words dropped
  end

  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      state_q <= S_EMPTY;
    end else begin
      state_q <= state_next;
    end
  end

  always_ff @(posedge clk_i) begin
    if (load || flow || drain) begin
      out_q <= drain ? skid_q : fetch_rsp_data_i;
    end
    if (fill) begin
      skid_q <= fetch_rsp_data_i;  // Decoder stalled, park the new word
    end
  end

  assign dec_instr_o = out_q;
  assign dec_valid_o = (state_q == S_BUSY) || (state_q == S_FULL);

endmodule

// File: logic/data_port.sv
// Load/store requester, one command at a time
// Relies on top arbiter priority so every request is granted at once

module data_port import fetch_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rstn_i,
  // Command input
  input  logic                  cmd_valid_i,
  input  logic                  cmd_write_i,
  input  logic [XLEN-1:0]       cmd_addr_i,
  input  logic [XLEN-1:0]       cmd_wdata_i,
  input  logic [STRB_WIDTH-1:0] cmd_strobe_i,
  output logic                  cmd_ready_o,
  // Memory request
  output logic                  data_req_valid_o,
  output logic                  data_req_write_o,
  output logic [XLEN-1:0]       data_req_addr_o,
  output logic [XLEN-1:0]       data_req_wdata_o,
  output logic [STRB_WIDTH-1:0] data_req_strobe_o,
  input  logic                  data_req_ready_i,
  // Memory response
  input  logic                  data_rsp_valid_i,
  input  logic [XLEN-1:0]       data_rsp_data_i,
  // Load result
  output logic                  load_valid_o,
  output logic [XLEN-1:0]       load_data_o
);

  typedef enum logic [1:0] {
    DP_IDLE,  // Accepting commands
    DP_REQ,   // Command on the memory request
    DP_WAIT,  // Memory access under way
    DP_DONE   // Load word on the result port
  } dp_state_e;

  dp_state_e state_q;

  // Command register
  always_ff @(posedge clk_i) begin
    if (cmd_valid_i && cmd_ready_o) begin
      data_req_write_o  <= cmd_write_i;
      data_req_addr_o   <= cmd_addr_i;
      data_req_wdata_o  <= cmd_wdata_i;
      data_req_strobe_o <= cmd_strobe_i;
    end
    if (data_rsp_valid_i) begin
      load_data_o <= data_rsp_data_i;  // Captured for the result pulse
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      state_q <= DP_IDLE;
    end else begin
      case (state_q)
        DP_IDLE: if (cmd_valid_i)      state_q <= DP_REQ;
        DP_REQ:  if (data_req_ready_i) state_q <= DP_WAIT;
        DP_WAIT: begin
          if (data_req_write_o) begin
            state_q <= DP_IDLE;  // Store already written
          end else if (data_rsp_valid_i) begin
            state_q <= DP_DONE;
          end
        end
        default: state_q <= DP_IDLE;
      endcase
    end
  end

  assign cmd_ready_o      = (state_q == DP_IDLE);
  assign data_req_valid_o = (state_q == DP_REQ);
  assign load_valid_o     = (state_q == DP_DONE);  // One-cycle pulse

endmodule

// File: logic/mem_arbiter.sv
// Fixed-priority arbiter for one memory with fixed one-cycle read latency
// Data side always wins, fetch waits for an idle data port

module mem_arbiter import fetch_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rstn_i,
  // Fetch side
  input  logic                  fetch_req_valid_i,
  output logic                  fetch_req_ready_o,
  input  logic [XLEN-1:0]       fetch_req_addr_i,
  output logic                  fetch_rsp_valid_o,
  output logic [XLEN-1:0]       fetch_rsp_data_o,
  // Data side
  input  logic                  data_req_valid_i,
  output logic                  data_req_ready_o,
  input  logic                  data_req_write_i,
  input  logic [XLEN-1:0]       data_req_addr_i,
  input  logic [XLEN-1:0]       data_req_wdata_i,
  input  logic [STRB_WIDTH-1:0] data_req_strobe_i,
  output logic                  data_rsp_valid_o,
  output logic [XLEN-1:0]       data_rsp_data_o,
  // Memory
  output logic                  mem_en_o,
  output logic                  mem_write_o,
  output logic [XLEN-1:0]       mem_addr_o,
  output logic [XLEN-1:0]       mem_wdata_o,
  output logic [STRB_WIDTH-1:0] mem_strobe_o,
  input  logic [XLEN-1:0]       mem_rdata_i
);

  arb_owner_e owner_q;
  logic       rd_pend_q;  // Read issued last cycle

  //////////////////////////////
  // Grant and request mux
  //////////////////////////////
  assign data_req_ready_o  = 1'b1;               // Highest priority
  assign fetch_req_ready_o = !data_req_valid_i;

  assign mem_en_o     = data_req_valid_i || fetch_req_valid_i;
  assign mem_write_o  = data_req_valid_i && data_req_write_i;  // Fetch never writes
  assign mem_addr_o   = data_req_valid_i ? data_req_addr_i : fetch_req_addr_i;
  assign mem_wdata_o  = data_req_wdata_i;
  assign mem_strobe_o = data_req_strobe_i;  // Only looked at on writes

  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      owner_q   <= OWNER_DATA;
      rd_pend_q <= 1'b0;
    end else begin
      rd_pend_q <= mem_en_o && !mem_write_o;  // Stores get no response
      if (mem_en_o) begin
        owner_q <= data_req_valid_i ? OWNER_DATA : OWNER_FETCH;
      end
    end
  end

  //////////////////////////////
  // Response steering
  //////////////////////////////
  assign fetch_rsp_valid_o = rd_pend_q && (owner_q == OWNER_FETCH);
  assign data_rsp_valid_o  = rd_pend_q && (owner_q == OWNER_DATA);
  assign fetch_rsp_data_o  = mem_rdata_i;
  assign data_rsp_data_o   = mem_rdata_i;

endmodule

// File: logic/word_mem.sv
// Single-port synchronous word memory, MEM_WORDS a power of two and at least 2
// Upper address bits are ignored so addresses alias modulo the depth

module word_mem import fetch_pkg::*; #(
  parameter int MEM_WORDS = 256
) (
  input  logic                  clk_i,
  input  logic                  en_i,
  input  logic                  write_i,
  input  logic [XLEN-1:0]       addr_i,
  input  logic [XLEN-1:0]       wdata_i,
  input  logic [STRB_WIDTH-1:0] strobe_i,
  output logic [XLEN-1:0]       rdata_o
);

  localparam int IDX_W = $clog2(MEM_WORDS);
  localparam int OFS_W = $clog2(STRB_WIDTH);  // Byte offset bits

  logic [XLEN-1:0]  mem_q [MEM_WORDS];
  logic [IDX_W-1:0] idx;

  assign idx = addr_i[OFS_W +: IDX_W];  // Word index only

  always_ff @(posedge clk_i) begin
    if (en_i) begin
      if (write_i) begin
        for (int b = 0; b < STRB_WIDTH; b++) begin
          if (strobe_i[b]) begin
            mem_q[idx][8*b +: 8] <= wdata_i[8*b +: 8];  // Merge enabled bytes
          end
        end
      end else begin
        rdata_o <= mem_q[idx];  // One-cycle read latency
      end
    end
  end

endmodule

// File: logic/fetch_top.sv
// Instruction-side memory subsystem, fetch and data port on one memory
// Memory never faults, fetch side is read-only

module fetch_top import fetch_pkg::*; #(
  parameter logic [XLEN-1:0] BOOT_ADDR = 32'h8000_0000,
  parameter int              MEM_WORDS = 256
) (
  input  logic                  clk_i,
  input  logic                  rstn_i,
  // Load/store commands
  input  logic                  cmd_valid_i,
  output logic                  cmd_ready_o,
  input  logic                  cmd_write_i,
  input  logic [XLEN-1:0]       cmd_addr_i,
  input  logic [XLEN-1:0]       cmd_wdata_i,
  input  logic [STRB_WIDTH-1:0] cmd_strobe_i,
  output logic                  load_valid_o,
  output logic [XLEN-1:0]       load_data_o,
  // Decoder
  output logic                  dec_valid_o,
  input  logic                  dec_ready_i,
  output logic [XLEN-1:0]       dec_instr_o,
  output logic [XLEN-1:0]       dec_pc_o,
  // Jump and trap
  input  logic                  jmp_valid_i,
  input  logic [XLEN-1:0]       jmp_addr_i,
  output logic                  exception_o,
  output logic [XLEN-1:0]       fault_addr_o
);

  logic                  fetch_req_valid, fetch_req_ready, fetch_rsp_valid;
  logic [XLEN-1:0]       fetch_req_addr, fetch_rsp_data;
  logic                  data_req_valid, data_req_ready, data_req_write, data_rsp_valid;
  logic [XLEN-1:0]       data_req_addr, data_req_wdata, data_rsp_data;
  logic [STRB_WIDTH-1:0] data_req_strobe, mem_strobe;
  logic                  mem_en, mem_write;
  logic [XLEN-1:0]       mem_addr, mem_wdata, mem_rdata;

  fetch_unit #(.BOOT_ADDR(BOOT_ADDR)) u_fetch (
    .clk_i, .rstn_i,
    .fetch_req_valid_o (fetch_req_valid),
    .fetch_req_ready_i (fetch_req_ready),
    .fetch_req_addr_o  (fetch_req_addr),
    .fetch_rsp_valid_i (fetch_rsp_valid),
    .fetch_rsp_data_i  (fetch_rsp_data),
    .dec_instr_o, .dec_pc_o, .dec_valid_o, .dec_ready_i,
    .jmp_valid_i, .jmp_addr_i, .exception_o, .fault_addr_o
  );

  data_port u_data (
    .clk_i, .rstn_i,
    .cmd_valid_i, .cmd_write_i, .cmd_addr_i, .cmd_wdata_i, .cmd_strobe_i, .cmd_ready_o,
    .data_req_valid_o  (data_req_valid),
    .data_req_write_o  (data_req_write),
    .data_req_addr_o   (data_req_addr),
    .data_req_wdata_o  (data_req_wdata),
    .data_req_strobe_o (data_req_strobe),
    .data_req_ready_i  (data_req_ready),
    .data_rsp_valid_i  (data_rsp_valid),
    .data_rsp_data_i   (data_rsp_data),
    .load_valid_o, .load_data_o
  );

  mem_arbiter u_arb (
    .clk_i, .rstn_i,
    .fetch_req_valid_i (fetch_req_valid),
    .fetch_req_ready_o (fetch_req_ready),
    .fetch_req_addr_i  (fetch_req_addr),
    .fetch_rsp_valid_o (fetch_rsp_valid),
    .fetch_rsp_data_o  (fetch_rsp_data),
    .data_req_valid_i  (data_req_valid),
    .data_req_ready_o  (data_req_ready),
    .data_req_write_i  (data_req_write),
    .data_req_addr_i   (data_req_addr),
    .data_req_wdata_i  (data_req_wdata),
    .data_req_strobe_i (data_req_strobe),
    .data_rsp_valid_o  (data_rsp_valid),
    .data_rsp_data_o   (data_rsp_data),
    .mem_en_o          (mem_en),
    .mem_write_o       (mem_write),
    .mem_addr_o        (mem_addr),
    .mem_wdata_o       (mem_wdata),
    .mem_strobe_o      (mem_strobe),
    .mem_rdata_i       (mem_rdata)
  );

  word_mem #(.MEM_WORDS(MEM_WORDS)) u_mem (
    .clk_i,
    .en_i     (mem_en),
    .write_i  (mem_write),
    .addr_i   (mem_addr),
    .wdata_i  (mem_wdata),
    .strobe_i (mem_strobe),
    .rdata_o  (mem_rdata)
  );

endmodule

// File: sim/fetch_tb.sv
// Memory is filled through the data port before any instruction is checked
// Stores during mixed traffic stay above the words the fetch stream reaches

module fetch_tb import fetch_pkg::*; ();

  localparam logic [XLEN-1:0] BOOT      = 32'h8000_0000;  // Aliases to word 0
  localparam int              MEM_WORDS = 64;
  localparam int              IDX_W     = $clog2(MEM_WORDS);
  localparam int              LIMIT     = 200;            // Cycles allowed per wait

  logic                  clk_i, rstn_i;
  logic                  cmd_valid_i, cmd_ready_o, cmd_write_i;
  logic [XLEN-1:0]       cmd_addr_i, cmd_wdata_i;
  logic [STRB_WIDTH-1:0] cmd_strobe_i;
  logic                  load_valid_o;
  logic [XLEN-1:0]       load_data_o;
  logic                  dec_valid_o, dec_ready_i;
  logic [XLEN-1:0]       dec_instr_o, dec_pc_o;
  logic                  jmp_valid_i;
  logic [XLEN-1:0]       jmp_addr_i;
  logic                  exception_o;
  logic [XLEN-1:0]       fault_addr_o;

  logic [XLEN-1:0] shadow [MEM_WORDS];    // Mirror of every store
  logic [XLEN-1:0] rng_q     = 32'd93930;  // LCG state
  logic [XLEN-1:0] exp_pc    = BOOT;       // Next PC the decoder should show
  logic [XLEN-1:0] exp_fault = '0;
  logic            exp_trap  = 1'b0;
  int              xfer_cnt  = 0;          // Decoder transfers seen

  fetch_top #(.BOOT_ADDR(BOOT), .MEM_WORDS(MEM_WORDS)) uut (.*);

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  //////////////////////////////
  // Reference model
  //////////////////////////////
  function automatic logic [XLEN-1:0] next_rand();
    rng_q = rng_q * 32'd1103515245 + 32'd12345;
    return rng_q;
  endfunction

  // Only word-index bits count so upper address bits alias
  function automatic logic [XLEN-1:0] ref_word(input logic [XLEN-1:0] addr);
    return shadow[addr[2 +: IDX_W]];
  endfunction

  task automatic merge_store(input logic [XLEN-1:0] addr, input logic [XLEN-1:0] wdata,
                             input logic [STRB_WIDTH-1:0] strb);
    for (int b = 0; b < STRB_WIDTH; b++) begin
      if (strb[b]) begin
        shadow[addr[2 +: IDX_W]][8*b +: 8] = wdata[8*b +: 8];  // Enabled bytes only
      end
    end
  endtask

  //////////////////////////////
  // Checks and waits
  //////////////////////////////
  task automatic abort_run();
    $display("Done: errors found");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_eq(input logic [XLEN-1:0] got, input logic [XLEN-1:0] exp,
                          input string what);
    if (got !== exp) begin
      $display("Error at time %0t: %s, got %h, expected %h", $time, what, got, exp);
      abort_run();
    end
  endtask

  task automatic report_timeout(input string what);
    $display("Timeout: %s did not happen within %0d cycles", what, LIMIT);
    abort_run();
  endtask

  // Stimulus changes a little after each rising edge
  task automatic next_cycle();
    @(posedge clk_i);
    #10;
  endtask

  task automatic issue_cmd(input logic wr, input logic [XLEN-1:0] addr,
                           input logic [XLEN-1:0] wdata, input logic [STRB_WIDTH-1:0] strb);
    int wait_cnt;
    int lat;
    wait_cnt     = 0;
    cmd_valid_i  = 1'b1;
    cmd_write_i  = wr;
    cmd_addr_i   = addr;
    cmd_wdata_i  = wdata;
    cmd_strobe_i = strb;
    while (!cmd_ready_o) begin
      next_cycle();
      wait_cnt++;
      if (wait_cnt > LIMIT) report_timeout("command acceptance");
    end
    next_cycle();  // Accepting edge just passed
    cmd_valid_i = 1'b0;
    if (wr) begin
      merge_store(addr, wdata, strb);
    end else begin
      lat = 0;
      while (!load_valid_o) begin
        next_cycle();
        lat++;
        if (lat > LIMIT) report_timeout("load result");
      end
      check_eq(32'(lat), 32'd2, "load latency");  // Two edges after acceptance
      check_eq(load_data_o, ref_word(addr), "load data");
    end
  endtask

  task automatic jump_to(input logic [XLEN-1:0] addr);
    jmp_valid_i = 1'b1;  // One-cycle strobe
    jmp_addr_i  = addr;
    next_cycle();
    jmp_valid_i = 1'b0;
  endtask

  task automatic wait_xfers(input int n);
    int target;
    int cyc;
    target = xfer_cnt + n;
    cyc    = 0;
    while (xfer_cnt < target) begin
      next_cycle();
      cyc++;
      if (cyc > LIMIT) report_timeout("decoder transfers");
    end
  endtask

  //////////////////////////////
  // Decoder monitor
  //////////////////////////////
  // Sampled mid-cycle so a transfer lands on the following rising edge
  always @(negedge clk_i) begin
    if (rstn_i) begin
      check_eq(32'(exception_o), 32'(exp_trap), "trap level");
      if (exp_trap) begin
        check_eq(fault_addr_o, exp_fault, "fault address");
        check_eq(32'(dec_valid_o), 32'd0, "decoder valid while trapped");
      end
      if (dec_valid_o && dec_ready_i) begin
        check_eq(dec_pc_o, exp_pc, "decoder PC");
        check_eq(dec_instr_o, ref_word(exp_pc), "decoder instruction");
        exp_pc = exp_pc + 32'd4;
        xfer_cnt++;
      end
      if (jmp_valid_i) begin
        if (jmp_addr_i[1:0] == 2'b00) begin
          exp_pc   = jmp_addr_i;  // Redirect takes effect at the edge
          exp_trap = 1'b0;
        end else begin
          exp_trap  = 1'b1;
          exp_fault = jmp_addr_i;
        end
      end
    end
  end

  //////////////////////////////
  // Scenarios
  //////////////////////////////
  initial begin
    logic [XLEN-1:0] r;
    rstn_i       = 1'b0;
    cmd_valid_i  = 1'b0;
    cmd_write_i  = 1'b0;
    cmd_addr_i   = '0;
    cmd_wdata_i  = '0;
    cmd_strobe_i = '0;
    dec_ready_i  = 1'b0;  // Boot words stay parked until the first jump
    jmp_valid_i  = 1'b0;
    jmp_addr_i   = '0;
    repeat (3) @(posedge clk_i);
    #10;
    rstn_i = 1'b1;

    // Reset state
    check_eq(32'(dec_valid_o), 32'd0, "decoder valid after reset");
    check_eq(32'(load_valid_o), 32'd0, "load valid after reset");
    check_eq(32'(exception_o), 32'd0, "trap after reset");
    check_eq(32'(cmd_ready_o), 32'd1, "command ready after reset");

    // Fill all words, then partial stores and loads through an alias
    for (int i = 0; i < MEM_WORDS; i++) begin
      issue_cmd(1'b1, BOOT + 32'(4 * i), next_rand(), 4'hF);
    end
    for (int i = 48; i < 56; i++) begin
      r = next_rand();
      issue_cmd(1'b1, 32'(4 * i), next_rand(), r[31:28]);
    end
    for (int i = 48; i < 56; i++) begin
      issue_cmd(1'b0, 32'h0001_0000 + 32'(4 * i), '0, '0);
    end

    // Sequential fetch from an aligned target
    jump_to(BOOT + 32'h8);
    dec_ready_i = 1'b1;
    wait_xfers(12);

    // Random back-pressure
    for (int i = 0; i < 80; i++) begin
      r = next_rand();
      dec_ready_i = r[30];
      next_cycle();
    end
    dec_ready_i = 1'b1;
    wait_xfers(4);

    // Jumps mid-stream with the buffer sometimes stalled
    for (int j = 0; j < 3; j++) begin
      r = next_rand();
      dec_ready_i = r[29];
      jump_to(BOOT + (r & 32'h0000_007C));
      dec_ready_i = 1'b1;
      wait_xfers(6);
    end

    // Misaligned jump traps and the next aligned jump recovers
    jump_to(BOOT + 32'h42);
    check_eq(32'(exception_o), 32'd1, "trap after misaligned jump");
    check_eq(fault_addr_o, BOOT + 32'h42, "fault address after misaligned jump");
    repeat (10) next_cycle();
    jump_to(BOOT + 32'h20);
    wait_xfers(8);
    check_eq(32'(exception_o), 32'd0, "trap after aligned jump");

    // Data traffic during fetch with stores kept to words 56 and up
    jump_to(BOOT);
    for (int i = 56; i < 62; i += 2) begin
      r = next_rand();
      issue_cmd(1'b1, 32'(4 * i), next_rand(), r[27:24]);
      issue_cmd(1'b0, 32'(4 * i), '0, '0);
      issue_cmd(1'b0, BOOT + 32'(4 * (i - 40)), '0, '0);  // Word on the fetch path
    end
    wait_xfers(4);

    $display("Done: no errors");
    $finish;
  end

endmodule

// File: fetch_top.f
logic/fetch_pkg.sv
logic/fetch_unit.sv
logic/data_port.sv
logic/mem_arbiter.sv
logic/word_mem.sv
logic/fetch_top.sv
sim/fetch_tb.sv

// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --timing
TOP       = fetch_tb
FILELIST  = fetch_top.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
